// File: hdl/led_string_pkg.sv
/* Line protocol timing, pixel memory geometry and sequencer states
   for the serial LED string controller. Referenced by scoped names. */

package led_string_pkg;

  // Symbol slot timing, in prescaler ticks
  localparam int SYM_CNT_W = 5;
  localparam logic [SYM_CNT_W-1:0] SYM_LEN = 5'd24; // Full slot
  localparam logic [SYM_CNT_W-1:0] T0_LEN  = 5'd8;  // Active part of a 0
  localparam logic [SYM_CNT_W-1:0] T1_LEN  = 5'd16; // Active part of a 1

  // Pixel memory
  localparam int PIX_W      = 8;
  localparam int PIX_ADDR_W = 10;
  localparam int PIX_DEPTH  = 1024;

  // Frame sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE,  // Waiting for start
    SEQ_FETCH, // Memory read issued
    SEQ_LOAD,  // Read data captured
    SEQ_SEND   // Bits offered to the encoder
  } seq_state_e;

endpackage

// File: hdl/led_regs_pkg.sv
/* Bus geometry, register map and field positions of the controller's
   slave interface. Referenced by scoped names. */

package led_regs_pkg;

  localparam int BUS_ADDR_W  = 13;
  localparam int BUS_DATA_W  = 32;
  localparam int PRESC_W     = 16; // Divider register width
  localparam int MEM_SEL_BIT = 12; // Set for the pixel memory window

  // Word offsets inside the register window
  typedef enum logic [1:0] {
    REG_CONFIG  = 2'd0,
    REG_DIVIDER = 2'd1,
    REG_CTRL    = 2'd2
  } reg_offset_e;

  // CONFIG fields
  localparam int ENABLE_BIT   = 31;
  localparam int IRQ_EN_BIT   = 30;
  localparam int POLARITY_BIT = 29;

  // CTRL fields, first index sits at the bottom
  localparam int START_BIT = 31;
  localparam int BUSY_BIT  = 29;
  localparam int LAST_LSB  = 16;

endpackage

// File: hdl/tick_prescaler.sv
/* Clock divider for the symbol slot tick. One tick every divider+1
   clocks while enabled. */

`timescale 1ns/1ps

module tick_prescaler (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             enable_i,
  input  logic [led_regs_pkg::PRESC_W-1:0] divider_i,
  output logic                             tick_o
);

  logic [led_regs_pkg::PRESC_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q >= divider_i) begin // Also recovers from a lowered divider
      cnt_q  <= '0;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q + 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// File: hdl/symbol_encoder.sv
/* Pulse-width encoder. Each accepted bit becomes one SYM_LEN-tick symbol
   on sout_o, active level first, then the idle level. */

`timescale 1ns/1ps

module symbol_encoder (
  input  logic clk,
  input  logic rst_n,
  input  logic enable_i,
  input  logic tick_i,
  input  logic polarity_i,  // Idle level of the line
  input  logic bit_value_i,
  input  logic bit_valid_i,
  output logic bit_ready_o,
  output logic sout_o
);

  logic [led_string_pkg::SYM_CNT_W-1:0] cnt_q;
  logic                                 bit_q;
  logic                                 pol_q;
  logic                                 at_rest;
  logic                                 accept;
  logic                                 active;

  assign at_rest = (cnt_q == led_string_pkg::SYM_LEN);
  assign accept  = tick_i && at_rest && bit_valid_i;

  // Still inside the active part of the current symbol
  assign active = (cnt_q < (bit_q ? led_string_pkg::T1_LEN : led_string_pkg::T0_LEN));

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      cnt_q       <= led_string_pkg::SYM_LEN;
      bit_ready_o <= 1'b0;
      sout_o      <= 1'b0;
    end else begin
      if (accept) begin
        cnt_q <= '0;
      end else if (tick_i && !at_rest) begin
        cnt_q <= cnt_q + 1'b1;
      end
      bit_ready_o <= accept; // One cycle after the bit was taken

      if (at_rest) begin
        sout_o <= polarity_i;
      end else begin
        sout_o <= active ? ~pol_q : pol_q;
      end
    end
  end

  // Symbol payload
  always_ff @(posedge clk) begin
    if (accept) begin
      bit_q <= bit_value_i;
      pol_q <= polarity_i;
    end
  end

endmodule

// File: hdl/frame_sequencer.sv
/* Frame sequencer. On start it reads pixel words first..last from port B
   of the pixel memory and hands their bits MSB first to the encoder. */

`timescale 1ns/1ps

module frame_sequencer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  enable_i,
  input  logic [led_string_pkg::PIX_ADDR_W-1:0] first_i,
  input  logic [led_string_pkg::PIX_ADDR_W-1:0] last_i,
  input  logic                                  start_i,
  output logic                                  busy_o,
  output logic                                  rd_en_o,
  output logic [led_string_pkg::PIX_ADDR_W-1:0] rd_addr_o,
  input  logic [led_string_pkg::PIX_W-1:0]      rd_data_i,
  output logic                                  bit_value_o,
  output logic                                  bit_valid_o,
  input  logic                                  bit_ready_i
);

  led_string_pkg::seq_state_e state_q;

  logic [led_string_pkg::PIX_ADDR_W-1:0] addr_q;
  logic [led_string_pkg::PIX_ADDR_W-1:0] last_q;
  logic [led_string_pkg::PIX_W-1:0]      shift_q;
  logic [2:0]                            bit_cnt_q;
  logic                                  byte_done;

  assign byte_done = bit_ready_i && (bit_cnt_q == 3'(led_string_pkg::PIX_W - 1));

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      state_q   <= led_string_pkg::SEQ_IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        led_string_pkg::SEQ_IDLE:  if (start_i) state_q <= led_string_pkg::SEQ_FETCH;
        led_string_pkg::SEQ_FETCH: state_q <= led_string_pkg::SEQ_LOAD;
        led_string_pkg::SEQ_LOAD:  state_q <= led_string_pkg::SEQ_SEND;
        led_string_pkg::SEQ_SEND: begin
          if (bit_ready_i) begin
            bit_cnt_q <= bit_cnt_q + 1'b1; // Wraps to 0 after bit 0
          end
          if (byte_done) begin
            state_q <= (addr_q != last_q) ? led_string_pkg::SEQ_FETCH
                                          : led_string_pkg::SEQ_IDLE;
          end
        end
        default: state_q <= led_string_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Word pointer and byte shifter
  always_ff @(posedge clk) begin
    if (state_q == led_string_pkg::SEQ_IDLE && start_i) begin
      addr_q <= first_i;
      last_q <= last_i;
    end else if (state_q == led_string_pkg::SEQ_SEND && byte_done) begin
      addr_q <= addr_q + 1'b1;
    end

    if (state_q == led_string_pkg::SEQ_LOAD) begin
      shift_q <= rd_data_i;
    end else if (state_q == led_string_pkg::SEQ_SEND && bit_ready_i) begin
      shift_q <= {shift_q[led_string_pkg::PIX_W-2:0], 1'b0};
    end
  end

  assign rd_en_o     = (state_q == led_string_pkg::SEQ_FETCH);
  assign rd_addr_o   = addr_q;
  assign bit_valid_o = (state_q == led_string_pkg::SEQ_SEND);
  assign bit_value_o = shift_q[led_string_pkg::PIX_W-1]; // MSB first
  assign busy_o      = (state_q != led_string_pkg::SEQ_IDLE);

endmodule

// File: hdl/pixel_ram.sv
/* Inferred pixel memory, 8 bits by 1024 words. Port A writes and reads,
   port B only reads; both return data one clock after enable. */

`timescale 1ns/1ps

module pixel_ram (
  input  logic                                  clk,
  input  logic                                  a_en_i,
  input  logic                                  a_we_i,
  input  logic [led_string_pkg::PIX_ADDR_W-1:0] a_addr_i,
  input  logic [led_string_pkg::PIX_W-1:0]      a_wdata_i,
  output logic [led_string_pkg::PIX_W-1:0]      a_rdata_o,
  input  logic                                  b_en_i,
  input  logic [led_string_pkg::PIX_ADDR_W-1:0] b_addr_i,
  output logic [led_string_pkg::PIX_W-1:0]      b_rdata_o
);

  logic [led_string_pkg::PIX_W-1:0] mem [led_string_pkg::PIX_DEPTH];

  always_ff @(posedge clk) begin
    if (a_en_i) begin
      if (a_we_i) mem[a_addr_i] <= a_wdata_i;
      a_rdata_o <= mem[a_addr_i]; // Read before write
    end
  end

  always_ff @(posedge clk) begin
    if (b_en_i) b_rdata_o <= mem[b_addr_i];
  end

endmodule

// File: hdl/led_registers.sv
/* Bus slave of the controller. Holds CONFIG, DIVIDER and CTRL, maps the
   pixel memory at MEM_SEL_BIT and raises the end-of-frame interrupt. */

`timescale 1ns/1ps

module led_registers (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    wb_cyc_i,
  input  logic                                    wb_stb_i,
  input  logic                                    wb_we_i,
  input  logic [led_regs_pkg::BUS_ADDR_W-1:0]     wb_adr_i,
  input  logic [led_regs_pkg::BUS_DATA_W-1:0]     wb_dat_i,
  output logic [led_regs_pkg::BUS_DATA_W-1:0]     wb_dat_o,
  output logic                                    wb_ack_o,
  output logic                                    enable_o,
  output logic                                    polarity_o,
  output logic [led_regs_pkg::PRESC_W-1:0]        divider_o,
  output logic [led_string_pkg::PIX_ADDR_W-1:0]   first_o,
  output logic [led_string_pkg::PIX_ADDR_W-1:0]   last_o,
  output logic                                    start_o,
  output logic                                    irq_o,
  input  logic                                    busy_i,
  output logic                                    mem_en_o,
  output logic                                    mem_we_o,
  output logic [led_string_pkg::PIX_ADDR_W-1:0]   mem_addr_o,
  output logic [led_string_pkg::PIX_W-1:0]        mem_wdata_o,
  input  logic [led_string_pkg::PIX_W-1:0]        mem_rdata_i
);

  led_regs_pkg::reg_offset_e offset;

  logic valid;      // Access pending, not yet acked
  logic mem_sel;
  logic reg_wr;
  logic mem_step_q; // Second cycle of a memory access
  logic irq_en_q;
  logic busy_q;

  assign valid   = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign mem_sel = wb_adr_i[led_regs_pkg::MEM_SEL_BIT];
  assign offset  = led_regs_pkg::reg_offset_e'(wb_adr_i[3:2]);
  assign reg_wr  = valid && !mem_sel && wb_we_i;

  // Port A is driven in the first cycle of a window access
  assign mem_en_o    = valid && mem_sel && !mem_step_q;
  assign mem_we_o    = mem_en_o && wb_we_i;
  assign mem_addr_o  = wb_adr_i[led_regs_pkg::MEM_SEL_BIT-1:2];
  assign mem_wdata_o = wb_dat_i[led_string_pkg::PIX_W-1:0];

  //////////////////////////////////////////////////
  // Handshake, configuration and interrupt
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack_o   <= 1'b0;
      mem_step_q <= 1'b0;
      enable_o   <= 1'b0;
      irq_en_q   <= 1'b0;
      polarity_o <= 1'b0;
      divider_o  <= '0;
      first_o    <= '0;
      last_o     <= '0;
      start_o    <= 1'b0;
      busy_q     <= 1'b0;
      irq_o      <= 1'b0;
    end else begin
      if (valid && mem_sel) begin
        mem_step_q <= !mem_step_q;
        wb_ack_o   <= mem_step_q; // Read data is back by now
      end else begin
        mem_step_q <= 1'b0;
        wb_ack_o   <= valid;
      end

      start_o <= 1'b0;
      if (reg_wr) begin
        case (offset)
          led_regs_pkg::REG_CONFIG: begin
            enable_o   <= wb_dat_i[led_regs_pkg::ENABLE_BIT];
            irq_en_q   <= wb_dat_i[led_regs_pkg::IRQ_EN_BIT];
            polarity_o <= wb_dat_i[led_regs_pkg::POLARITY_BIT];
          end
          led_regs_pkg::REG_DIVIDER: divider_o <= wb_dat_i[led_regs_pkg::PRESC_W-1:0];
          led_regs_pkg::REG_CTRL: begin
            first_o <= wb_dat_i[led_string_pkg::PIX_ADDR_W-1:0];
            last_o  <= wb_dat_i[led_regs_pkg::LAST_LSB +: led_string_pkg::PIX_ADDR_W];
            start_o <= wb_dat_i[led_regs_pkg::START_BIT]; // Self-clearing
          end
          default: ;
        endcase
      end

      busy_q <= busy_i;
      irq_o  <= irq_en_q && busy_q && !busy_i; // Frame just ended
    end
  end

  // Read mux, captured together with ack
  always_ff @(posedge clk) begin
    if (valid) begin
      wb_dat_o <= '0;
      if (mem_sel) begin
        wb_dat_o[led_string_pkg::PIX_W-1:0] <= mem_rdata_i;
      end else begin
        case (offset)
          led_regs_pkg::REG_CONFIG: begin
            wb_dat_o[led_regs_pkg::ENABLE_BIT]   <= enable_o;
            wb_dat_o[led_regs_pkg::IRQ_EN_BIT]   <= irq_en_q;
            wb_dat_o[led_regs_pkg::POLARITY_BIT] <= polarity_o;
          end
          led_regs_pkg::REG_DIVIDER: wb_dat_o[led_regs_pkg::PRESC_W-1:0] <= divider_o;
          led_regs_pkg::REG_CTRL: begin
            wb_dat_o[led_regs_pkg::BUSY_BIT] <= busy_i;
            wb_dat_o[led_regs_pkg::LAST_LSB +: led_string_pkg::PIX_ADDR_W] <= last_o;
            wb_dat_o[led_string_pkg::PIX_ADDR_W-1:0] <= first_o;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: hdl/string_led_controller.sv
/* Top of the serial LED string controller. Bus slave and pixel memory on
   one side, prescaler, sequencer and encoder driving sout_o on the other. */

`timescale 1ns/1ps

module string_led_controller (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [led_regs_pkg::BUS_ADDR_W-1:0] wb_adr_i,
  input  logic [led_regs_pkg::BUS_DATA_W-1:0] wb_dat_i,
  output logic [led_regs_pkg::BUS_DATA_W-1:0] wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                irq_o,
  output logic                                sout_o
);

  // Configuration and status
  logic                                  enable;
  logic                                  polarity;
  logic [led_regs_pkg::PRESC_W-1:0]      divider;
  logic [led_string_pkg::PIX_ADDR_W-1:0] first;
  logic [led_string_pkg::PIX_ADDR_W-1:0] last;
  logic                                  start;
  logic                                  busy;

  // Memory ports
  logic                                  a_en;
  logic                                  a_we;
  logic [led_string_pkg::PIX_ADDR_W-1:0] a_addr;
  logic [led_string_pkg::PIX_W-1:0]      a_wdata;
  logic [led_string_pkg::PIX_W-1:0]      a_rdata;
  logic                                  b_en;
  logic [led_string_pkg::PIX_ADDR_W-1:0] b_addr;
  logic [led_string_pkg::PIX_W-1:0]      b_rdata;

  // Bit stream
  logic                                  tick;
  logic                                  bit_value;
  logic                                  bit_valid;
  logic                                  bit_ready;

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////
  led_registers u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .enable_o    (enable),
    .polarity_o  (polarity),
    .divider_o   (divider),
    .first_o     (first),
    .last_o      (last),
    .start_o     (start),
    .irq_o       (irq_o),
    .busy_i      (busy),
    .mem_en_o    (a_en),
    .mem_we_o    (a_we),
    .mem_addr_o  (a_addr),
    .mem_wdata_o (a_wdata),
    .mem_rdata_i (a_rdata)
  );

  pixel_ram u_ram (
    .clk       (clk),
    .a_en_i    (a_en),
    .a_we_i    (a_we),
    .a_addr_i  (a_addr),
    .a_wdata_i (a_wdata),
    .a_rdata_o (a_rdata),
    .b_en_i    (b_en),
    .b_addr_i  (b_addr),
    .b_rdata_o (b_rdata)
  );

  //////////////////////////////////////////////////
  // Line side
  //////////////////////////////////////////////////
  frame_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (enable),
    .first_i     (first),
    .last_i      (last),
    .start_i     (start),
    .busy_o      (busy),
    .rd_en_o     (b_en),
    .rd_addr_o   (b_addr),
    .rd_data_i   (b_rdata),
    .bit_value_o (bit_value),
    .bit_valid_o (bit_valid),
    .bit_ready_i (bit_ready)
  );

  tick_prescaler u_presc (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable_i  (enable),
    .divider_i (divider),
    .tick_o    (tick)
  );

  symbol_encoder u_enc (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (enable),
    .tick_i      (tick),
    .polarity_i  (polarity),
    .bit_value_i (bit_value),
    .bit_valid_i (bit_valid),
    .bit_ready_o (bit_ready),
    .sout_o      (sout_o)
  );

endmodule

// File: testbench/string_led_asserts.sv
/* Bus, interrupt and line assertions, bound into the controller top level.
   fail_cnt holds the number of failed assertions. */

`timescale 1ns/1ps

module string_led_asserts (
  input logic clk,
  input logic rst_n,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic irq_i,
  input logic sout_i,
  input logic enable_i
);

  int fail_cnt = 0;

  ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("wb_ack_o stayed high for two cycles");
    end

  // Ack only answers a request that was live when it was registered
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack_i) |-> $past(cyc_i && stb_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("wb_ack_o rose without cyc and stb");
    end

  irq_single: assert property (@(posedge clk) disable iff (!rst_n) irq_i |=> !irq_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("irq_o lasted more than one cycle");
    end

  // Line register follows enable one clock later
  sout_disabled: assert property (@(posedge clk) disable iff (!rst_n) !enable_i |=> !sout_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("sout_o high while the controller is disabled");
    end

endmodule

bind string_led_controller string_led_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cyc_i    (wb_cyc_i),
  .stb_i    (wb_stb_i),
  .ack_i    (wb_ack_o),
  .irq_i    (irq_o),
  .sout_i   (sout_o),
  .enable_i (enable)
);

// File: testbench/tb_string_led_controller.sv
/* Directed testbench of the LED string controller. Drives the bus on the
   falling edge and decodes sout_o back into bits by pulse width. */

`timescale 1ns/1ps

module tb_string_led_controller;

  localparam logic [12:0] CONFIG_ADDR  = 13'h000;
  localparam logic [12:0] DIVIDER_ADDR = 13'h004;
  localparam logic [12:0] CTRL_ADDR    = 13'h008;
  localparam logic [12:0] MEM_BASE     = 13'h1000; // Pixel i at MEM_BASE + 4*i
  localparam int BUS_TIMEOUT  = 16;
  localparam int LINE_TIMEOUT = 2000;
  localparam int DIV          = 1; // Divider for every frame
  localparam int DEPTH        = led_string_pkg::PIX_DEPTH;

  localparam logic [31:0] ENABLE   = 32'd1 << led_regs_pkg::ENABLE_BIT;
  localparam logic [31:0] IRQ_EN   = 32'd1 << led_regs_pkg::IRQ_EN_BIT;
  localparam logic [31:0] POLARITY = 32'd1 << led_regs_pkg::POLARITY_BIT;
  localparam logic [31:0] START    = 32'd1 << led_regs_pkg::START_BIT;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [12:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        irq_o;
  logic        sout_o;

  string_led_controller u_dut (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Reporting and bus access
  //////////////////////////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s expected 0x%08h, got 0x%08h",
                          $time, name, exp, act));
    end
  endtask

  always @(u_dut.u_asserts.fail_cnt) begin
    if (u_dut.u_asserts.fail_cnt != 0) begin
      abort_run($sformatf("A bound assertion failed at %0t", $time));
    end
  end

  // Holds the request until ack, then one idle cycle
  task automatic wait_ack();
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > BUS_TIMEOUT) abort_run("Timeout: the bus slave never acknowledged");
    end while (wb_ack_o !== 1'b1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk);
  endtask

  task automatic bus_write(input logic [12:0] addr, input logic [31:0] data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = addr;
    wb_dat_i = data;
    wait_ack();
  endtask

  task automatic bus_read(input logic [12:0] addr, output logic [31:0] data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = addr;
    wb_ack_o_wait: begin
      int t;
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (t > BUS_TIMEOUT) abort_run("Timeout: the bus slave never acknowledged a read");
      end while (wb_ack_o !== 1'b1);
    end
    data     = wb_dat_o; // Valid in the ack cycle
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(negedge clk);
  endtask

  // One symbol: active pulse width in clocks gives the bit
  task automatic decode_bit(input logic pol, output logic bit_val);
    int t;
    int width;
    t = 0;
    while (sout_o !== ~pol) begin
      @(negedge clk);
      t++;
      if (t > LINE_TIMEOUT) abort_run("Timeout: no symbol pulse on sout_o");
    end
    width = 0;
    while (sout_o === ~pol) begin
      @(negedge clk);
      width++;
      if (width > LINE_TIMEOUT) abort_run("Timeout: sout_o stuck at its active level");
    end
    if (width == int'(led_string_pkg::T0_LEN) * (DIV + 1)) begin
      bit_val = 1'b0;
    end else if (width == int'(led_string_pkg::T1_LEN) * (DIV + 1)) begin
      bit_val = 1'b1;
    end else begin
      abort_run($sformatf("Pulse of %0d clocks on sout_o is neither a 0 nor a 1", width));
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic register_readback();
    logic [31:0] rd;
    bus_write(CONFIG_ADDR, 32'hFFFF_FFFF);
    bus_read(CONFIG_ADDR, rd);
    check_value("CONFIG", rd, ENABLE | IRQ_EN | POLARITY);
    bus_write(CONFIG_ADDR, 32'h0);
    bus_write(DIVIDER_ADDR, 32'hABCD_1234);
    bus_read(DIVIDER_ADDR, rd);
    check_value("DIVIDER", rd, 32'hABCD_1234 & ((32'd1 << led_regs_pkg::PRESC_W) - 1));
    // Start is ignored while disabled and never reads back
    bus_write(CTRL_ADDR, 32'hFFFF_FFFF);
    bus_read(CTRL_ADDR, rd);
    check_value("CTRL", rd, (32'(DEPTH - 1) << led_regs_pkg::LAST_LSB) | 32'(DEPTH - 1));
  endtask

  task automatic pixel_memory_readback();
    logic [31:0] wdata [8];
    int          idx [8];
    logic [31:0] rd;
    int          k;
    for (k = 0; k < 8; k++) begin
      idx[k]   = k * 128 + ($urandom % 128); // One word per 128-word block
      wdata[k] = $urandom;
      bus_write(MEM_BASE + 13'(idx[k] * 4), wdata[k]);
    end
    for (k = 0; k < 8; k++) begin
      bus_read(MEM_BASE + 13'(idx[k] * 4), rd);
      check_value($sformatf("pixel word %0d", idx[k]), rd, {24'h0, wdata[k][7:0]});
    end
  endtask

  task automatic send_frame(input logic pol, input int first, input logic [7:0] pix0,
                            input logic [7:0] pix1);
    logic [7:0]  pix [2];
    logic [31:0] rd;
    logic        bit_val;
    int          k;
    int          b;
    pix[0] = pix0;
    pix[1] = pix1;
    bus_write(MEM_BASE + 13'(first * 4), {24'h0, pix0});
    bus_write(MEM_BASE + 13'((first + 1) * 4), {24'h0, pix1});
    bus_write(DIVIDER_ADDR, DIV);
    bus_write(CONFIG_ADDR, ENABLE | (pol ? POLARITY : 32'h0));
    check_value("sout_o before start", sout_o, pol);
    bus_write(CTRL_ADDR, START | (32'(first + 1) << led_regs_pkg::LAST_LSB) | 32'(first));
    for (k = 0; k < 2; k++) begin
      for (b = 7; b >= 0; b--) begin // MSB first
        decode_bit(pol, bit_val);
        check_value($sformatf("sout_o bit %0d of pixel %0d", b, first + k), bit_val, pix[k][b]);
      end
    end
    repeat ((int'(led_string_pkg::SYM_LEN) - int'(led_string_pkg::T1_LEN)) * (DIV + 1)) begin
      @(negedge clk);
      check_value("sout_o idle level", sout_o, pol);
    end
    bus_read(CTRL_ADDR, rd);
    check_value("CTRL busy after frame", rd[led_regs_pkg::BUSY_BIT], 0);
  endtask

  task automatic busy_and_interrupt();
    logic [31:0] rd;
    int          idx;
    int          t;
    int          irq_cnt;
    idx = $urandom % (DEPTH - 1);
    bus_write(MEM_BASE + 13'(idx * 4), $urandom);
    bus_write(CONFIG_ADDR, ENABLE | IRQ_EN);
    bus_write(CTRL_ADDR, START | (32'(idx) << led_regs_pkg::LAST_LSB) | 32'(idx));
    bus_read(CTRL_ADDR, rd);
    check_value("CTRL busy during frame", rd[led_regs_pkg::BUSY_BIT], 1);
    t = 0;
    while (irq_o !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > LINE_TIMEOUT) abort_run("Timeout: no interrupt at the end of the frame");
    end
    irq_cnt = 1;
    repeat (2 * int'(led_string_pkg::SYM_LEN) * (DIV + 1)) begin // Also drains the last symbol
      @(negedge clk);
      if (irq_o === 1'b1) irq_cnt++;
    end
    check_value("irq_o pulse count", irq_cnt, 1);
    bus_read(CTRL_ADDR, rd);
    check_value("CTRL busy after frame", rd[led_regs_pkg::BUSY_BIT], 0);

    // Same frame, interrupt masked
    bus_write(CONFIG_ADDR, ENABLE);
    bus_write(CTRL_ADDR, START | (32'(idx) << led_regs_pkg::LAST_LSB) | 32'(idx));
    irq_cnt = 0;
    repeat (LINE_TIMEOUT) begin
      @(negedge clk);
      if (irq_o === 1'b1) irq_cnt++;
    end
    check_value("irq_o pulse count with irq disabled", irq_cnt, 0);
    bus_read(CTRL_ADDR, rd);
    check_value("CTRL busy after masked frame", rd[led_regs_pkg::BUSY_BIT], 0);

    // Disable in the middle of a two-word frame
    bus_write(CONFIG_ADDR, ENABLE | POLARITY);
    bus_write(CTRL_ADDR, START | (32'(idx + 1) << led_regs_pkg::LAST_LSB) | 32'(idx));
    t = 0;
    while (sout_o !== 1'b0) begin
      @(negedge clk);
      t++;
      if (t > LINE_TIMEOUT) abort_run("Timeout: no symbol pulse before the disable");
    end
    bus_write(CONFIG_ADDR, POLARITY);
    bus_read(CTRL_ADDR, rd);
    check_value("CTRL busy after disable", rd[led_regs_pkg::BUSY_BIT], 0);
    repeat (int'(led_string_pkg::SYM_LEN) * (DIV + 1)) begin
      @(negedge clk);
      check_value("sout_o while disabled", sout_o, 0);
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////
  initial begin
    int         first;
    logic [7:0] pix0;
    logic [7:0] pix1;
    rst_n    = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    void'($urandom(32'h1d844c31));
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("wb_ack_o after reset", wb_ack_o, 0);
    check_value("irq_o after reset", irq_o, 0);
    check_value("sout_o after reset", sout_o, 0);

    register_readback();
    pixel_memory_readback();
    first = $urandom % (DEPTH - 1);
    pix0  = $urandom;
    pix1  = $urandom;
    send_frame(1'b0, first, pix0, pix1);
    send_frame(1'b1, first, pix0, pix1); // Inverted line, same pixels
    busy_and_interrupt();

    if (u_dut.u_asserts.fail_cnt != 0) begin
      abort_run($sformatf("%0d bound assertion failures", u_dut.u_asserts.fail_cnt));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: vlog.f
hdl/led_string_pkg.sv
hdl/led_regs_pkg.sv
hdl/tick_prescaler.sv
hdl/symbol_encoder.sv
hdl/frame_sequencer.sv
hdl/pixel_ram.sv
hdl/led_registers.sv
hdl/string_led_controller.sv
testbench/string_led_asserts.sv
testbench/tb_string_led_controller.sv
